// File: common/huffman_code_pkg.sv
// table geometry and code words; table codes are left aligned, bits below the length are ignored
package huffman_code_pkg;

    localparam int table_addr_bits = 9;                      // colour flag is the top bit
    localparam int table_depth     = 1 << table_addr_bits;
    localparam int code_bits       = 16;
    localparam int literal_bits    = 11;
    localparam int word_bits       = code_bits + literal_bits; // 27, msb aligned output
    localparam int active_window   = 10;                     // cycles a pop keeps the pipe busy

    localparam logic [7:0] code_eob      = 8'h00;
    localparam logic [7:0] code_zrl      = 8'hf0;
    localparam logic [3:0] dc_low_nibble = 4'hf;             // dc address is {category, f}

    typedef struct packed {
        logic [code_bits-1:0] code;        // left aligned
        logic [3:0]           code_len_m1; // length minus one
    } table_entry_t;

    typedef struct packed {
        logic [table_addr_bits-1:0] addr;
        table_entry_t               entry;
    } table_write_t;

    typedef struct packed {
        logic [word_bits-1:0] bits; // msb aligned code and literal
        logic [4:0]           len;  // total valid bits
    } code_word_t;

endpackage

// File: common/jpeg_token_pkg.sv
// token word layout; the top bit picks the view, no other field is checked for consistency
package jpeg_token_pkg;

    localparam int value_bits      = 12;                      // signed dc/ac value
    localparam int run_bits        = 6;                       // zero run field
    localparam int run_zrl_shift   = 4;                       // low run bits kept for next ac
    localparam int zrl_cnt_bits    = run_bits - run_zrl_shift; // f0 code counter
    localparam int fifo_depth      = 4;
    localparam int fifo_ptr_bits   = $clog2(fifo_depth);
    localparam int fifo_count_bits = fifo_ptr_bits + 1;

    // dc or ac coefficient
    typedef struct packed {
        logic                         is_coef; // 1 here
        logic                         is_dc;   // 0 for ac
        logic                         color;   // chroma, only read on dc
        logic                         last;    // dc: last block, ac: last word
        logic signed [value_bits-1:0] value;
    } coef_view_t;

    // zero run or end of block
    typedef struct packed {
        logic                is_coef;  // 0 here
        logic                spare_hi;
        logic                last;     // eob: last word of block
        logic                is_eob;   // 0 means zero run
        logic [5:0]          spare_lo;
        logic [run_bits-1:0] run;      // [5:4] f0 count, [3:0] run for next ac
    } ctrl_view_t;

    typedef union packed {
        coef_view_t coef_view;
        ctrl_view_t ctrl_view;
    } token_word_u;

endpackage

// File: huffman/code_merge.sv
// in_valid is the table read strobe; entry and literal must arrive two cycles after it
`timescale 1ns/1ps

module code_merge (
    input  logic                                      xclk,
    input  logic                                      rst,
    input  logic                                      in_valid,
    input  huffman_code_pkg::table_entry_t            entry,
    input  logic [huffman_code_pkg::literal_bits-1:0] literal,
    input  logic [3:0]                                literal_len,
    output huffman_code_pkg::code_word_t              out,
    output logic                                      out_valid
);

    logic [1:0]                                  valid_d;   // matches table latency
    logic [4:0]                                  code_len;
    logic [4:0]                                  total_len;
    logic [4:0]                                  lit_shift;
    logic [huffman_code_pkg::code_bits-1:0]      code_mask;
    logic [huffman_code_pkg::literal_bits-1:0]   lit_clean;
    logic [huffman_code_pkg::word_bits-1:0]      merged;

    always_comb begin
        code_len  = 5'(entry.code_len_m1) + 5'd1;
        total_len = code_len + 5'(literal_len);
        lit_shift = 5'(huffman_code_pkg::word_bits) - total_len;  // literal lsb position
        code_mask = ~({huffman_code_pkg::code_bits{1'b1}} >> code_len);
        lit_clean = literal & ~({huffman_code_pkg::literal_bits{1'b1}} << literal_len);
        merged    = {entry.code & code_mask, {huffman_code_pkg::literal_bits{1'b0}}}
                    | (huffman_code_pkg::word_bits'(lit_clean) << lit_shift);
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            valid_d   <= '0;
            out_valid <= 1'b0;
        end else begin
            valid_d   <= {valid_d[0], in_valid};
            out_valid <= valid_d[1];
        end
    end

    always_ff @(posedge xclk) begin
        if (valid_d[1]) begin
            out.bits <= merged;
            out.len  <= total_len;
        end
    end

    // table code plus encoder literal has to fit the output word
    a_len_fits: assert property (@(posedge xclk) disable iff (rst)
        valid_d[1] |-> total_len <= 5'(huffman_code_pkg::word_bits));

endmodule

// File: huffman/huffman_encoder.sv
// run tokens must directly precede their ac token; six cycles from pop to code, each f0 adds a slot
`timescale 1ns/1ps

module huffman_encoder (
    input  logic                                         xclk,
    input  logic                                         rst,
    input  jpeg_token_pkg::token_word_u                  fifo_token,
    input  logic                                         fifo_nempty,
    output logic                                         fifo_re,
    output logic [huffman_code_pkg::table_addr_bits-1:0] table_rd_addr,
    output logic                                         table_re,
    output logic [huffman_code_pkg::literal_bits-1:0]    literal_late,
    output logic [3:0]                                   literal_len_late,
    output logic                                         flush
);

    logic take_dc, take_ac, take_eob, take_run;
    logic take_last_blk, take_last_word;
    logic run_hold;                                       // one idle cycle after a run
    logic [jpeg_token_pkg::zrl_cnt_bits-1:0] zrl_cnt;     // f0 codes still to send
    logic [3:0] run_nib;                                  // run for the next ac
    logic color_r;                                        // sticky, from last dc
    logic dc1, ac1, eob1, zrl1;
    logic [3:0] nib1;
    logic signed [jpeg_token_pkg::value_bits-1:0] sval;
    logic dc2, ac2, eob2, zrl2, color2;
    logic [3:0] nib2;
    logic [3:0] category;
    logic [huffman_code_pkg::literal_bits-1:0] literal;
    logic [7:0] addr_low;
    logic [huffman_code_pkg::literal_bits-1:0] lit3, lit4;
    logic [3:0] len3, len4;
    logic last_blk_r, ready_flush, active;
    logic [huffman_code_pkg::active_window-1:0] active_r;

    // decode through both union views
    assign take_dc  = fifo_re && fifo_token.coef_view.is_coef && fifo_token.coef_view.is_dc;
    assign take_ac  = fifo_re && fifo_token.coef_view.is_coef && !fifo_token.coef_view.is_dc;
    assign take_eob = fifo_re && !fifo_token.ctrl_view.is_coef && fifo_token.ctrl_view.is_eob;
    assign take_run = fifo_re && !fifo_token.ctrl_view.is_coef && !fifo_token.ctrl_view.is_eob;
    assign take_last_blk  = take_dc && fifo_token.coef_view.last;
    assign take_last_word = (take_ac && fifo_token.coef_view.last)
                            || (take_eob && fifo_token.ctrl_view.last);

    assign fifo_re = fifo_nempty && !run_hold && (zrl_cnt == '0);
    assign zrl1    = zrl_cnt != '0;                       // f0 slot this cycle
    assign active  = fifo_re || active_r[0];

    // stage 1, token taken
    always_ff @(posedge xclk) begin
        if (rst) begin
            run_hold <= 1'b0;
            zrl_cnt  <= '0;
            run_nib  <= '0;
            color_r  <= 1'b0;                             // luma after reset
            dc1      <= 1'b0;
            ac1      <= 1'b0;
            eob1     <= 1'b0;
        end else begin
            run_hold <= take_run;
            if (take_run)
                zrl_cnt <= fifo_token.ctrl_view.run[jpeg_token_pkg::run_bits-1:
                                                    jpeg_token_pkg::run_zrl_shift];
            else if (zrl1)
                zrl_cnt <= zrl_cnt - 1'b1;
            if (fifo_re)
                run_nib <= take_run ? fifo_token.ctrl_view.run[3:0] : 4'b0;
            if (take_dc) color_r <= fifo_token.coef_view.color;
            dc1  <= take_dc;
            ac1  <= take_ac;
            eob1 <= take_eob;
        end
    end

    always_ff @(posedge xclk) begin
        sval <= fifo_token.coef_view.value;               // garbage on ctrl, unused then
        nib1 <= run_nib;                                  // run seen before this ac
    end

    varlen_encode varlen_encode_i (
        .xclk     (xclk),
        .value    (sval),
        .category (category),                             // valid in stage 2
        .literal  (literal)
    );

    // stage 2, address forming
    always_ff @(posedge xclk) begin
        if (rst) begin
            dc2      <= 1'b0;
            ac2      <= 1'b0;
            eob2     <= 1'b0;
            zrl2     <= 1'b0;
            table_re <= 1'b0;
        end else begin
            dc2      <= dc1;
            ac2      <= ac1;
            eob2     <= eob1;
            zrl2     <= zrl1;
            table_re <= dc2 || ac2 || eob2 || zrl2;
        end
    end

    always_ff @(posedge xclk) begin
        color2 <= color_r;
        nib2   <= nib1;
    end

    always_comb begin
        if (eob2)      addr_low = huffman_code_pkg::code_eob;
        else if (zrl2) addr_low = huffman_code_pkg::code_zrl;
        else if (dc2)  addr_low = {category, huffman_code_pkg::dc_low_nibble};
        else           addr_low = {nib2, category};      // ac
    end

    // literal follows the table read, two more stages
    always_ff @(posedge xclk) begin
        table_rd_addr    <= {color2, addr_low};           // colour picks the table half
        lit3             <= literal;
        len3             <= (eob2 || zrl2) ? 4'b0 : category;
        lit4             <= lit3;
        len4             <= len3;
        literal_late     <= lit4;
        literal_len_late <= len4;
    end

    // end of frame
    always_ff @(posedge xclk) begin
        if (rst || flush)       last_blk_r <= 1'b0;
        else if (take_last_blk) last_blk_r <= 1'b1;

        if (rst || flush)                      ready_flush <= 1'b0;
        else if (last_blk_r && take_last_word) ready_flush <= 1'b1;

        if (rst)          active_r <= '0;
        else if (fifo_re) active_r <= '1;                 // restart the window
        else              active_r <= active_r >> 1;

        if (rst) flush <= 1'b0;
        else     flush <= ready_flush && !active && !flush; // single pulse
    end

    // stall logic keeps f0 slots apart from popped tokens
    a_one_kind: assert property (@(posedge xclk) disable iff (rst)
        $onehot0({dc1, ac1, eob1, zrl1}));

endmodule

// File: huffman/huffman_table.sv
// read data is valid two cycles after re; a write lands at the clock edge, no read-during-write bypass
`timescale 1ns/1ps

module huffman_table (
    input  logic                                         xclk,
    input  huffman_code_pkg::table_write_t               table_wr,
    input  logic                                         we,
    input  logic [huffman_code_pkg::table_addr_bits-1:0] rd_addr,
    input  logic                                         re,
    output huffman_code_pkg::table_entry_t               entry
);

    huffman_code_pkg::table_entry_t mem [huffman_code_pkg::table_depth];
    huffman_code_pkg::table_entry_t rd_data;  // ram output register
    logic                           re_d;     // enables the second stage

    always_ff @(posedge xclk) begin
        if (we) mem[table_wr.addr] <= table_wr.entry;
    end

    always_ff @(posedge xclk) begin
        if (re) rd_data <= mem[rd_addr];   // stage 1
        re_d <= re;
        if (re_d) entry <= rd_data;        // stage 2, holds between reads
    end

endmodule

// File: huffman/varlen_encode.sv
// one register stage; -2048 is outside the jpeg range and gives a wrong category
`timescale 1ns/1ps

module varlen_encode (
    input  logic                                      xclk,
    input  logic signed [jpeg_token_pkg::value_bits-1:0] value,
    output logic [3:0]                                category,
    output logic [huffman_code_pkg::literal_bits-1:0] literal
);

    logic [jpeg_token_pkg::value_bits-1:0] mag;   // absolute value
    logic [jpeg_token_pkg::value_bits-1:0] ones;  // one's complement for negatives
    logic [3:0]                            cat_c;

    always_comb begin
        mag   = value[jpeg_token_pkg::value_bits-1] ? -value : value;
        ones  = value[jpeg_token_pkg::value_bits-1] ? value - 1'b1 : value;
        cat_c = '0;
        for (int i = 0; i < jpeg_token_pkg::value_bits; i++) begin
            if (mag[i]) cat_c = 4'(i + 1); // highest set bit wins
        end
    end

    always_ff @(posedge xclk) begin
        category <= cat_c;
        // keep only the low category bits
        literal  <= ones[huffman_code_pkg::literal_bits-1:0]
                    & ~({huffman_code_pkg::literal_bits{1'b1}} << cat_c);
    end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_jpeg_huffman -f sim.f -Mdir obj_dir

out=$(./obj_dir/Vtb_jpeg_huffman)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// File: sim.f
common/jpeg_token_pkg.sv
common/huffman_code_pkg.sv
source/token_fifo.sv
huffman/varlen_encode.sv
huffman/huffman_table.sv
huffman/code_merge.sv
huffman/huffman_encoder.sv
source/jpeg_huffman_top.sv
sim/huffman_checker.sv
sim/tb_jpeg_huffman.sv

// File: sim/huffman_checker.sv
// reference model of the coder; table writes must finish before the tokens that read them
`timescale 1ns/1ps

module huffman_checker (
    input logic                           xclk,
    input logic                           rst,
    input jpeg_token_pkg::token_word_u    token,
    input logic                           token_valid,
    input huffman_code_pkg::table_write_t table_wr,
    input logic                           table_we,
    input huffman_code_pkg::code_word_t   code_out,
    input logic                           code_valid,
    input logic                           flush,
    input logic [127:0]                   test_name     // row name, ascii
);

    huffman_code_pkg::table_entry_t tbl [huffman_code_pkg::table_depth]; // mirror of the dut table
    logic [31:0]  exp_q [$];                  // {bits, len} in token order
    logic [127:0] name_q [$];
    logic [31:0]  exp_w;
    logic [127:0] exp_name;
    logic         color;                      // sticky, from the last dc
    logic         last_blk;                   // last-block dc seen, waiting for its last word
    logic [3:0]   nib;                        // short run for the next ac
    int           flush_expected = 0;
    int           flush_seen = 0;
    int           checks = 0;
    int           value_errors = 0;
    int           other_errors = 0;

    // jpeg magnitude category, bits needed for |v|
    function automatic int category_of(input int v);
        int mag;
        int cat;
        mag = (v < 0) ? -v : v;
        cat = 0;
        while ((mag >> cat) != 0)
            cat++;
        return cat;
    endfunction

    // code bits from the top, literal right below them
    task automatic push_word(input logic [8:0] addr, input int v, input logic has_lit);
        huffman_code_pkg::table_entry_t e;
        logic [26:0] w;
        int clen;
        int cat;
        int lit;
        int pos;
        e    = tbl[addr];
        clen = int'(e.code_len_m1) + 1;
        cat  = has_lit ? category_of(v) : 0;
        lit  = (v < 0) ? v + (1 << cat) - 1 : v;      // negative values keep v-1 low bits
        w    = '0;
        pos  = 26;
        for (int i = 0; i < clen; i++) begin
            w[pos] = e.code[15-i];
            pos--;
        end
        for (int i = cat - 1; i >= 0; i--) begin
            w[pos] = lit[i];
            pos--;
        end
        exp_q.push_back({w, 5'(clen + cat)});
        name_q.push_back(test_name);
    endtask

    task automatic model_token(input jpeg_token_pkg::token_word_u t);
        int v;
        logic [3:0] run_nib;
        logic last_word;
        v         = $signed(t.coef_view.value);
        run_nib   = nib;
        nib       = '0;                                 // any token uses up the run
        last_word = 1'b0;
        if (t.coef_view.is_coef && t.coef_view.is_dc) begin
            color = t.coef_view.color;                  // applies to this dc too
            push_word({color, 4'(category_of(v)), 4'hf}, v, 1'b1);
            if (t.coef_view.last)
                last_blk = 1'b1;
        end else if (t.coef_view.is_coef) begin
            push_word({color, run_nib, 4'(category_of(v))}, v, 1'b1);
            last_word = t.coef_view.last;
        end else if (t.ctrl_view.is_eob) begin
            push_word({color, 8'h00}, 0, 1'b0);
            last_word = t.ctrl_view.last;
        end else begin
            for (int i = 0; i < (t.ctrl_view.run >> 4); i++)
                push_word({color, 8'hf0}, 0, 1'b0); // one f0 per 16 zeros
            nib = t.ctrl_view.run[3:0];
        end
        if (last_word && last_blk) begin
            flush_expected++;
            last_blk = 1'b0;
        end
    endtask

    always @(posedge xclk) begin
        if (rst) begin
            color    = 1'b0;
            nib      = '0;
            last_blk = 1'b0;
        end else begin
            if (table_we)
                tbl[table_wr.addr] = table_wr.entry;
            if (token_valid)
                model_token(token);
            if (code_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Error: code word %h/%0d came out with nothing expected",
                             code_out.bits, code_out.len);
                    other_errors++;
                end else begin
                    exp_w    = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    checks++;
                    if ({code_out.bits, code_out.len} !== exp_w) begin
                        $display("Fail %0s: expected %h/%0d actual %h/%0d", exp_name,
                                 exp_w[31:5], exp_w[4:0], code_out.bits, code_out.len);
                        value_errors++;
                    end
                end
            end
            if (flush) begin
                flush_seen++;
                if (flush_seen > flush_expected) begin
                    $display("Error: flush pulse without a finished last block");
                    other_errors++;
                end else if (exp_q.size() != 0) begin
                    $display("Error: flush came before the final code word");
                    other_errors++;
                end
            end
        end
    end

    task automatic final_check();
        if (exp_q.size() != 0) begin
            $display("Error: %0d expected code words never came out", exp_q.size());
            other_errors++;
        end
        if (flush_seen != flush_expected) begin
            $display("Error: saw %0d flush pulses, wanted %0d", flush_seen, flush_expected);
            other_errors++;
        end
        if (checks == 0) begin
            $display("Error: no code word was compared");
            other_errors++;
        end
    endtask

endmodule

// File: sim/tb_jpeg_huffman.sv
// table loads first; token rows are spaced so the fifo never holds more than four
`timescale 1ns/1ps

module tb_jpeg_huffman;

    typedef struct {
        logic [127:0] name;
        logic [15:0]  tok;
        int           gap;                  // idle cycles after the token
    } row_t;

    logic                           xclk;
    logic                           rst;
    jpeg_token_pkg::token_word_u    token;
    logic                           token_valid;
    huffman_code_pkg::table_write_t table_wr;
    logic                           table_we;
    huffman_code_pkg::code_word_t   code_out;
    logic                           code_valid;
    logic                           flush;
    logic [127:0]                   test_name;
    logic [15:0]                    lfsr;   // galois, taps b400
    row_t                           rows [$];

    jpeg_huffman_top jpeg_huffman_top_i (.*);

    huffman_checker huffman_checker_i (.*);

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [19:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[18:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [15:0] coef(input logic dc, input logic color, input logic last,
                                         input int value);
        return {1'b1, dc, color, last, 12'(value)};
    endfunction

    function automatic logic [15:0] run_tok(input logic [5:0] run);
        return {10'b0, run};
    endfunction

    function automatic logic [15:0] eob(input logic last);
        return {2'b00, last, 1'b1, 12'b0};
    endfunction

    task automatic add_row(input logic [127:0] name, input logic [15:0] tok, input int gap);
        row_t r;
        r.name = name;
        r.tok  = tok;
        r.gap  = gap;
        rows.push_back(r);
    endtask

    initial begin
        xclk = 1'b0;
        forever #2 xclk = ~xclk;
    end

    // limit grows with the row count
    initial begin
        @(posedge xclk);                    // rows are filled at time zero
        repeat (rows.size() * 40 + huffman_code_pkg::table_depth + 10) @(posedge xclk);
        $display("Error: watchdog expired before the run finished");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [19:0] rnd;
        rst         = 1'b1;
        token       = '0;
        token_valid = 1'b0;
        table_wr    = '0;
        table_we    = 1'b0;
        test_name   = "reset";
        lfsr        = 16'd6;
        add_row("dc_pos", coef(1, 0, 0, 5), 2);
        add_row("ac_plain", coef(0, 0, 0, -1), 1);
        add_row("eob_block", eob(1), 2);            // last word, no last block
        add_row("dc_neg", coef(1, 0, 0, -3), 2);
        add_row("run_short", run_tok(3), 2);
        add_row("ac_run3", coef(0, 0, 0, 7), 2);
        add_row("dc_zero", coef(1, 0, 0, 0), 2);
        add_row("run_zrl1", run_tok(16), 3);
        add_row("ac_after_zrl1", coef(0, 0, 0, 1), 2);
        add_row("run_zrl2", run_tok(37), 4);        // two f0, nibble 5
        add_row("ac_after_zrl2", coef(0, 0, 0, -100), 2);
        add_row("run_zrl3", run_tok(63), 5);
        add_row("ac_run63", coef(0, 0, 1, 2), 2);
        add_row("dc_chroma", coef(1, 1, 0, 12), 2);
        add_row("ac_chroma", coef(0, 0, 0, -600), 2);
        add_row("eob_chroma", eob(1), 2);
        add_row("dc_luma", coef(1, 0, 0, -2047), 2); // category 11
        add_row("eob_luma", eob(1), 2);
        add_row("dc_last_blk", coef(1, 0, 1, 9), 2);
        add_row("run_final", run_tok(2), 2);
        add_row("ac_final", coef(0, 0, 0, -5), 2);
        add_row("eob_final", eob(1), 2);            // ends the frame
        repeat (10) @(negedge xclk);
        rst       = 1'b0;
        test_name = "table_load";
        for (int a = 0; a < huffman_code_pkg::table_depth; a++) begin
            take_bits(20, rnd);
            table_wr.addr  = 9'(a);
            table_wr.entry = rnd;
            table_we       = 1'b1;
            @(negedge xclk);
        end
        table_we = 1'b0;
        foreach (rows[i]) begin
            test_name   = rows[i].name;
            token       = rows[i].tok;
            token_valid = 1'b1;
            @(negedge xclk);
            token_valid = 1'b0;
            repeat (rows[i].gap) @(negedge xclk);
        end
        wait (flush === 1'b1);
        repeat (20) @(negedge xclk);            // catch late words or a second flush
        huffman_checker_i.final_check();
        $display("checks %0d, value errors %0d, other errors %0d", huffman_checker_i.checks,
                 huffman_checker_i.value_errors, huffman_checker_i.other_errors);
        if (huffman_checker_i.value_errors == 0 && huffman_checker_i.other_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: source/jpeg_huffman_top.sv
// single clock; no back-pressure on either side, table writes may overlap encoding
`timescale 1ns/1ps

module jpeg_huffman_top (
    input  logic                           xclk,
    input  logic                           rst,
    input  jpeg_token_pkg::token_word_u    token,
    input  logic                           token_valid,
    input  huffman_code_pkg::table_write_t table_wr,
    input  logic                           table_we,
    output huffman_code_pkg::code_word_t   code_out,
    output logic                           code_valid,
    output logic                           flush
);

    jpeg_token_pkg::token_word_u                  fifo_token;
    logic                                         fifo_nempty;
    logic                                         fifo_re;
    logic [huffman_code_pkg::table_addr_bits-1:0] table_rd_addr;
    logic                                         table_re;
    huffman_code_pkg::table_entry_t               table_entry;
    logic [huffman_code_pkg::literal_bits-1:0]    literal_late;
    logic [3:0]                                   literal_len_late;

    token_fifo token_fifo_i (
        .xclk     (xclk),
        .rst      (rst),
        .wr_token (token),
        .we       (token_valid),
        .re       (fifo_re),
        .rd_token (fifo_token),
        .nempty   (fifo_nempty)
    );

    huffman_encoder huffman_encoder_i (
        .xclk             (xclk),
        .rst              (rst),
        .fifo_token       (fifo_token),
        .fifo_nempty      (fifo_nempty),
        .fifo_re          (fifo_re),
        .table_rd_addr    (table_rd_addr),
        .table_re         (table_re),
        .literal_late     (literal_late),
        .literal_len_late (literal_len_late),
        .flush            (flush)
    );

    huffman_table huffman_table_i (
        .xclk     (xclk),
        .table_wr (table_wr),
        .we       (table_we),
        .rd_addr  (table_rd_addr),
        .re       (table_re),
        .entry    (table_entry)           // two cycles after re
    );

    code_merge code_merge_i (
        .xclk        (xclk),
        .rst         (rst),
        .in_valid    (table_re),
        .entry       (table_entry),
        .literal     (literal_late),
        .literal_len (literal_len_late),
        .out         (code_out),
        .out_valid   (code_valid)
    );

endmodule

// File: source/token_fifo.sv
// show-ahead token buffer with no back-pressure; writer keeps at most four tokens outstanding
`timescale 1ns/1ps

module token_fifo (
    input  logic                        xclk,
    input  logic                        rst,
    input  jpeg_token_pkg::token_word_u wr_token,
    input  logic                        we,
    input  logic                        re,
    output jpeg_token_pkg::token_word_u rd_token,
    output logic                        nempty
);

    jpeg_token_pkg::token_word_u                  mem [jpeg_token_pkg::fifo_depth];
    logic [jpeg_token_pkg::fifo_ptr_bits-1:0]     wr_ptr;
    logic [jpeg_token_pkg::fifo_ptr_bits-1:0]     rd_ptr;
    logic [jpeg_token_pkg::fifo_count_bits-1:0]   count;
    logic                                         full;

    assign full     = count == jpeg_token_pkg::fifo_count_bits'(jpeg_token_pkg::fifo_depth);
    assign nempty   = count != '0;
    assign rd_token = mem[rd_ptr]; // head word visible before the pop

    always_ff @(posedge xclk) begin
        if (we) mem[wr_ptr] <= wr_token;        // storage, no reset
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (we) wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two, wraps
            if (re) rd_ptr <= rd_ptr + 1'b1;
            case ({we, re})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // idle or push+pop
            endcase
        end
    end

    // producer overran the buffer
    a_no_overflow: assert property (@(posedge xclk) disable iff (rst) !(we && full && !re));
    // encoder popped an empty buffer
    a_no_underflow: assert property (@(posedge xclk) disable iff (rst) re |-> nempty);

endmodule
